// ==== logic/exu_md_pkg.sv ====
// shared widths, op encoding and payload structs; every struct is sized by XLEN, so any WIDTH below must equal it
package exu_md_pkg;

    // register data width of the core
    localparam int XLEN = 32;

    // destination register address width
    localparam int REG_ADDR_W = 5;

    // commit tag width from dispatch
    localparam int COMMIT_ID_W = 8;

    // cycles from divider start edge to its valid pulse
    localparam int DIV_LAT = XLEN + 2;

    // top bit set for the divide class
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } md_op_e;

    // one request from dispatch
    typedef struct packed {
        md_op_e                 op;
        logic [XLEN-1:0]        rs1;
        logic [XLEN-1:0]        rs2;
        logic [REG_ADDR_W-1:0]  waddr;
        logic                   we;
        logic [COMMIT_ID_W-1:0] commit_id;
    } md_req_t;

    // writeback info kept next to a result in flight
    typedef struct packed {
        logic [REG_ADDR_W-1:0]  waddr;
        logic                   we;
        logic [COMMIT_ID_W-1:0] commit_id;
    } md_tag_t;

    // writeback payload
    typedef struct packed {
        logic [XLEN-1:0]        wdata;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [COMMIT_ID_W-1:0] commit_id;
    } md_wb_t;

endpackage

// ==== logic/exu_mul.sv ====
// two-stage multiplier plus output hold register; WIDTH must equal the package XLEN
`timescale 1ns/1ps

module exu_mul #(
    parameter int WIDTH = 32
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_i,
    input  logic                flush_i,
    input  exu_md_pkg::md_req_t req_data_i,
    input  logic                grant_i,
    output logic                stall_o,
    output logic                res_valid_o,
    output exu_md_pkg::md_wb_t  res_o
);

    logic                      adv;
    logic                      accept;
    logic                      a_sgn;
    logic                      b_sgn;
    logic                      s1_v_q;
    logic                      s2_v_q;
    logic                      out_v_q;
    logic                      s1_hi_q;
    logic                      s2_hi_q;
    logic signed [WIDTH:0]     a_q;
    logic signed [WIDTH:0]     b_q;
    logic signed [2*WIDTH+1:0] prod_full;
    logic [2*WIDTH-1:0]        prod_q;
    exu_md_pkg::md_tag_t       s1_tag_q;
    exu_md_pkg::md_tag_t       s2_tag_q;
    exu_md_pkg::md_wb_t        out_q;

    // whole pipe moves only if the hold register can take a result
    assign adv    = !out_v_q || grant_i;
    assign accept = req_i && !flush_i && adv;

    assign stall_o = req_i && !flush_i && !adv;

    // rs1 signed for MULH and MULHSU, rs2 only for MULH
    assign a_sgn = (req_data_i.op == exu_md_pkg::MULH) || (req_data_i.op == exu_md_pkg::MULHSU);
    assign b_sgn = (req_data_i.op == exu_md_pkg::MULH);

    // extra bit makes every case a signed product
    assign prod_full = a_q * b_q;

    // valid bits
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_v_q  <= 1'b0;
            s2_v_q  <= 1'b0;
            out_v_q <= 1'b0;
        end else if (adv) begin
            s1_v_q  <= accept;
            s2_v_q  <= s1_v_q;
            // we low results never reach the hold register
            out_v_q <= s2_v_q && s2_tag_q.we;
        end
    end

    // stage one operands
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q      <= {a_sgn && req_data_i.rs1[WIDTH-1], req_data_i.rs1[WIDTH-1:0]};
            b_q      <= {b_sgn && req_data_i.rs2[WIDTH-1], req_data_i.rs2[WIDTH-1:0]};
            s1_hi_q  <= (req_data_i.op != exu_md_pkg::MUL);
            s1_tag_q <= '{waddr: req_data_i.waddr, we: req_data_i.we,
                          commit_id: req_data_i.commit_id};
        end
    end

    // stage two product and hold register
    always_ff @(posedge clk) begin
        if (adv) begin
            prod_q          <= prod_full[2*WIDTH-1:0];
            s2_hi_q         <= s1_hi_q;
            s2_tag_q        <= s1_tag_q;
            out_q.wdata     <= s2_hi_q ? prod_q[2*WIDTH-1:WIDTH] : prod_q[WIDTH-1:0];
            out_q.waddr     <= s2_tag_q.waddr;
            out_q.commit_id <= s2_tag_q.commit_id;
        end
    end

    assign res_valid_o = out_v_q;
    assign res_o       = out_q;

endmodule

// ==== logic/exu_div_ctrl.sv ====
// one divide in flight at a time; a new divide waits until the divider is idle and the held result has left
`timescale 1ns/1ps

module exu_div_ctrl (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        req_i,
    input  logic                        flush_i,
    input  exu_md_pkg::md_req_t         req_data_i,
    input  logic                        div_busy_i,
    input  logic                        div_valid_i,
    input  logic [exu_md_pkg::XLEN-1:0] div_result_i,
    input  logic                        grant_i,
    output logic                        div_start_o,
    output logic [exu_md_pkg::XLEN-1:0] div_dividend_o,
    output logic [exu_md_pkg::XLEN-1:0] div_divisor_o,
    output exu_md_pkg::md_op_e          div_op_o,
    output logic                        stall_o,
    output logic                        res_valid_o,
    output exu_md_pkg::md_wb_t          res_o
);

    logic                        is_div;
    logic                        start;
    logic                        held_q;
    logic [exu_md_pkg::XLEN-1:0] result_q;
    // tag of the divide running in the divider
    exu_md_pkg::md_tag_t         tag_q;
    // tag of the result sitting in the holding register
    exu_md_pkg::md_tag_t         tag2_q;

    // flushed requests never reach the divider
    assign is_div = req_i && !flush_i;

    // divider idle, no result on its way out, holding register empty
    assign start = is_div && !div_busy_i && !div_valid_i && !held_q;

    // holding register state
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            held_q <= 1'b0;
        end else if (div_valid_i) begin
            held_q <= 1'b1;
        end else if (held_q && (grant_i || !tag2_q.we)) begin
            // granted, or no writeback wanted
            held_q <= 1'b0;
        end
    end

    // tag captured at start
    always_ff @(posedge clk) begin
        if (start) begin
            tag_q.waddr     <= req_data_i.waddr;
            tag_q.we        <= req_data_i.we;
            tag_q.commit_id <= req_data_i.commit_id;
        end
    end

    // result and its tag move to the second stage together
    always_ff @(posedge clk) begin
        if (div_valid_i) begin
            tag2_q   <= tag_q;
            result_q <= div_result_i;
        end
    end

    // divider operands come straight from dispatch
    assign div_start_o    = start;
    assign div_dividend_o = req_data_i.rs1;
    assign div_divisor_o  = req_data_i.rs2;
    assign div_op_o       = req_data_i.op;

    // only a live divide request can stall
    assign stall_o = is_div && (div_busy_i || div_valid_i || held_q);

    // we low results are dropped here
    assign res_valid_o = held_q && tag2_q.we;

    always_comb begin
        res_o.wdata     = result_q;
        res_o.waddr     = tag2_q.waddr;
        res_o.commit_id = tag2_q.commit_id;
    end

endmodule

// ==== logic/exu_divider.sv ====
// radix-2 restoring divider with fixed WIDTH+2 latency; start_i is ignored while busy
`timescale 1ns/1ps

module exu_divider #(
    parameter int WIDTH = 32
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               start_i,
    input  logic [WIDTH-1:0]   dividend_i,
    input  logic [WIDTH-1:0]   divisor_i,
    input  exu_md_pkg::md_op_e op_i,
    output logic               busy_o,
    output logic               valid_o,
    output logic [WIDTH-1:0]   result_o
);

    localparam int CNT_W = $clog2(WIDTH + 2);
    // counter value of the sign fix cycle
    localparam logic [CNT_W-1:0] CNT_FIX = CNT_W'(WIDTH);
    // counter value of the last busy cycle
    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(WIDTH + 1);

    logic             go;
    logic             busy_q;
    logic             valid_q;
    logic [CNT_W-1:0] cnt_q;
    logic             is_signed;
    logic             is_rem;
    logic             dvd_neg;
    logic             dvs_neg;
    logic [WIDTH-1:0] dvd_mag;
    logic [WIDTH-1:0] dvs_mag;
    logic [WIDTH-1:0] quo_q;
    logic [WIDTH-1:0] rem_q;
    logic [WIDTH-1:0] dvs_q;
    logic [WIDTH-1:0] dvd_q;
    logic [WIDTH-1:0] res_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             rem_sel_q;
    logic             zero_q;
    logic             ovf_q;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   diff;
    logic [WIDTH-1:0] quo_fix;
    logic [WIDTH-1:0] rem_fix;
    logic [WIDTH-1:0] res_d;

    assign go = start_i && !busy_q;

    // op decode
    assign is_signed = (op_i == exu_md_pkg::DIV) || (op_i == exu_md_pkg::REM);
    assign is_rem    = (op_i == exu_md_pkg::REM) || (op_i == exu_md_pkg::REMU);

    // operand magnitudes
    assign dvd_neg = is_signed && dividend_i[WIDTH-1];
    assign dvs_neg = is_signed && divisor_i[WIDTH-1];
    assign dvd_mag = dvd_neg ? -dividend_i : dividend_i;
    assign dvs_mag = dvs_neg ? -divisor_i : divisor_i;

    // one trial subtraction per step
    assign shifted = {rem_q, quo_q[WIDTH-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    // sign fix and RISC-V special results
    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_comb begin
        if (zero_q) begin
            res_d = rem_sel_q ? dvd_q : '1;
        end else if (ovf_q) begin
            res_d = rem_sel_q ? '0 : dvd_q;
        end else begin
            res_d = rem_sel_q ? rem_fix : quo_fix;
        end
    end

    // sequencing
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            valid_q <= 1'b0;
            if (go) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                if (cnt_q == CNT_DONE) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + CNT_W'(1);
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (go) begin
            quo_q     <= dvd_mag;
            rem_q     <= '0;
            dvs_q     <= dvs_mag;
            dvd_q     <= dividend_i;
            neg_quo_q <= dvd_neg ^ dvs_neg;
            neg_rem_q <= dvd_neg;
            rem_sel_q <= is_rem;
            zero_q    <= (divisor_i == '0);
            ovf_q     <= is_signed && (dividend_i == {1'b1, {(WIDTH - 1){1'b0}}})
                         && (divisor_i == '1);
        end else if (busy_q && (cnt_q < CNT_FIX)) begin
            quo_q <= {quo_q[WIDTH-2:0], ~diff[WIDTH]};
            rem_q <= diff[WIDTH] ? shifted[WIDTH-1:0] : diff[WIDTH-1:0];
        end else if (busy_q && (cnt_q == CNT_FIX)) begin
            res_q <= res_d;
        end
    end

    assign busy_o   = busy_q;
    assign valid_o  = valid_q;
    assign result_o = res_q;

endmodule

// ==== logic/exu_wb_arb.sv ====
// fixed multiply priority, except a divide result already shown under back-pressure keeps the port
`timescale 1ns/1ps

module exu_wb_arb (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               mul_valid_i,
    input  exu_md_pkg::md_wb_t mul_res_i,
    input  logic               div_valid_i,
    input  exu_md_pkg::md_wb_t div_res_i,
    input  logic               wb_ready_i,
    output logic               mul_grant_o,
    output logic               div_grant_o,
    output logic               wb_valid_o,
    output exu_md_pkg::md_wb_t wb_o
);

    logic sel_div;
    logic lock_q;

    // divide wins only when multiply is idle or divide already holds the port
    assign sel_div = div_valid_i && (!mul_valid_i || lock_q);

    // remember a divide result that was shown but not taken
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lock_q <= 1'b0;
        end else begin
            lock_q <= sel_div && !wb_ready_i;
        end
    end

    assign wb_valid_o = mul_valid_i || div_valid_i;
    assign wb_o       = sel_div ? div_res_i : mul_res_i;

    // grant pulses only on an accepting cycle
    assign mul_grant_o = mul_valid_i && !sel_div && wb_ready_i;
    assign div_grant_o = sel_div && wb_ready_i;

endmodule

// ==== logic/exu_muldiv_top.sv ====
// multiply/divide cluster top; one request per cycle, results may come back out of program order
`timescale 1ns/1ps

module exu_muldiv_top #(
    parameter int WIDTH = exu_md_pkg::XLEN
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                req_i,
    input  logic                flush_i,
    input  exu_md_pkg::md_req_t req_data_i,
    output logic                stall_o,
    input  logic                wb_ready_i,
    output logic                wb_valid_o,
    output exu_md_pkg::md_wb_t  wb_o
);

    logic               is_div_class;
    logic               mul_req;
    logic               div_req;
    logic               mul_stall;
    logic               div_stall;
    logic               mul_valid;
    logic               div_res_valid;
    logic               mul_grant;
    logic               div_grant;
    exu_md_pkg::md_wb_t mul_res;
    exu_md_pkg::md_wb_t div_res;
    logic               div_start;
    logic               div_busy;
    logic               div_valid;
    logic [WIDTH-1:0]   div_dividend;
    logic [WIDTH-1:0]   div_divisor;
    logic [WIDTH-1:0]   div_result;
    exu_md_pkg::md_op_e div_op;

    // steer by class bit of the op
    assign is_div_class = req_data_i.op[2];
    assign mul_req      = req_i && !is_div_class;
    assign div_req      = req_i && is_div_class;

    assign stall_o = is_div_class ? div_stall : mul_stall;

    exu_mul #(
        .WIDTH(WIDTH)
    ) u_exu_mul (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (mul_req),
        .flush_i    (flush_i),
        .req_data_i (req_data_i),
        .grant_i    (mul_grant),
        .stall_o    (mul_stall),
        .res_valid_o(mul_valid),
        .res_o      (mul_res)
    );

    exu_div_ctrl u_exu_div_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .req_i         (div_req),
        .flush_i       (flush_i),
        .req_data_i    (req_data_i),
        .div_busy_i    (div_busy),
        .div_valid_i   (div_valid),
        .div_result_i  (div_result),
        .grant_i       (div_grant),
        .div_start_o   (div_start),
        .div_dividend_o(div_dividend),
        .div_divisor_o (div_divisor),
        .div_op_o      (div_op),
        .stall_o       (div_stall),
        .res_valid_o   (div_res_valid),
        .res_o         (div_res)
    );

    exu_divider #(
        .WIDTH(WIDTH)
    ) u_exu_divider (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (div_start),
        .dividend_i(div_dividend),
        .divisor_i (div_divisor),
        .op_i      (div_op),
        .busy_o    (div_busy),
        .valid_o   (div_valid),
        .result_o  (div_result)
    );

    exu_wb_arb u_exu_wb_arb (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .mul_valid_i(mul_valid),
        .mul_res_i  (mul_res),
        .div_valid_i(div_res_valid),
        .div_res_i  (div_res),
        .wb_ready_i (wb_ready_i),
        .mul_grant_o(mul_grant),
        .div_grant_o(div_grant),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

endmodule

// ==== tb/exu_muldiv_properties.sv ====
// sampled on the rising edge, so inputs must settle between edges; reports only through $error
`timescale 1ns/1ps

module exu_muldiv_properties (
    input logic               clk,
    input logic               arst_n_i,
    input logic               req_i,
    input logic               stall_o,
    input logic               wb_ready_i,
    input logic               wb_valid_o,
    input exu_md_pkg::md_wb_t wb_o
);

    // result shown under back-pressure stays put
    property wb_hold_p;
        @(posedge clk) disable iff (!arst_n_i)
            (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(wb_o));
    endproperty

    // no stall without a request
    property stall_needs_req_p;
        @(posedge clk) disable iff (!arst_n_i)
            !req_i |-> !stall_o;
    endproperty

    // port quiet in reset
    property wb_idle_in_reset_p;
        @(posedge clk) !arst_n_i |-> !wb_valid_o;
    endproperty

    wb_hold_a: assert property (wb_hold_p)
        else $error("writeback moved or dropped while wb_ready_i was low");

    stall_needs_req_a: assert property (stall_needs_req_p)
        else $error("stall_o high without a request");

    wb_idle_in_reset_a: assert property (wb_idle_in_reset_p)
        else $error("wb_valid_o high during reset");

endmodule

// ==== tb/tb_exu_muldiv.sv ====
// one DUT at XLEN 32; commit ids wrap at 256, so only a few results may be in flight at once
`timescale 1ns/1ps

module tb_exu_muldiv;

    localparam int XLEN        = exu_md_pkg::XLEN;
    localparam int ID_W        = exu_md_pkg::COMMIT_ID_W;
    localparam int IDS         = 2 ** ID_W;
    localparam int MAX_CYCLES  = 20000;
    localparam int MUL_LAT     = 2;
    localparam int DIV_WB_LAT  = exu_md_pkg::DIV_LAT + 1;
    // longest tail after the last request, with back-pressure
    localparam int DRAIN_LIMIT = 200;
    localparam logic [31:0] SEED = 32'h4d02_bd77;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN - 1){1'b0}}};

    logic                clk = 1'b0;
    logic                arst_n_i;
    logic                req_i;
    logic                flush_i;
    logic                wb_ready_i;
    logic                stall_o;
    logic                wb_valid_o;
    exu_md_pkg::md_req_t req_data_i;
    exu_md_pkg::md_wb_t  wb_o;

    // stimulus and scoreboard state
    logic [31:0]                  lcg_state;
    logic [31:0]                  ready_state;
    logic                         random_ready;
    logic                         lat_en;
    logic [ID_W-1:0]              next_id;
    logic                         pending [IDS];
    logic                         lat_chk [IDS];
    logic [XLEN-1:0]              exp_data [IDS];
    logic [exu_md_pkg::REG_ADDR_W-1:0] exp_addr [IDS];
    int                           acc_edge [IDS];
    int                           exp_lat [IDS];
    int                           cycle_cnt = 0;
    int                           outstanding;
    int                           checks;
    int                           errors;
    int                           tests;
    int                           test_checks;
    int                           test_errors;
    string                        test_name;

    always #20 clk = ~clk;

    exu_muldiv_top #(
        .WIDTH(XLEN)
    ) u_exu_muldiv_top (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .flush_i   (flush_i),
        .req_data_i(req_data_i),
        .stall_o   (stall_o),
        .wb_ready_i(wb_ready_i),
        .wb_valid_o(wb_valid_o),
        .wb_o      (wb_o)
    );

    bind exu_muldiv_top exu_muldiv_properties u_exu_muldiv_properties (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .stall_o   (stall_o),
        .wb_ready_i(wb_ready_i),
        .wb_valid_o(wb_valid_o),
        .wb_o      (wb_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    // half the operands are 0, -1, most negative or small
    function automatic logic [XLEN-1:0] pick_operand(input logic [31:0] sel, input logic [31:0] v);
        logic [XLEN-1:0] res;
        case (sel[31:29])
            3'd0:    res = '0;
            3'd1:    res = '1;
            3'd2:    res = {1'b1, {(XLEN - 1){1'b0}}};
            3'd3:    res = XLEN'(v[7:0]);
            default: res = v[XLEN-1:0];
        endcase
        return res;
    endfunction

    // RISC-V M results, with div by zero and overflow spelled out
    function automatic logic [XLEN-1:0] model_result(input exu_md_pkg::md_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]      a_s;
        logic [2*XLEN-1:0]      a_u;
        logic [2*XLEN-1:0]      b_s;
        logic [2*XLEN-1:0]      b_u;
        logic [2*XLEN-1:0]      prod;
        logic signed [XLEN-1:0] sres;
        logic [XLEN-1:0]        res;
        logic                   ovf;
        a_s  = {{XLEN{a[XLEN-1]}}, a};
        a_u  = {{XLEN{1'b0}}, a};
        b_s  = {{XLEN{b[XLEN-1]}}, b};
        b_u  = {{XLEN{1'b0}}, b};
        ovf  = (a == {1'b1, {(XLEN - 1){1'b0}}}) && (b == '1);
        prod = '0;
        case (op)
            exu_md_pkg::MUL: begin
                prod = a_u * b_u;
                res  = prod[XLEN-1:0];
            end
            exu_md_pkg::MULH: begin
                prod = a_s * b_s;
                res  = prod[2*XLEN-1:XLEN];
            end
            exu_md_pkg::MULHSU: begin
                prod = a_s * b_u;
                res  = prod[2*XLEN-1:XLEN];
            end
            exu_md_pkg::MULHU: begin
                prod = a_u * b_u;
                res  = prod[2*XLEN-1:XLEN];
            end
            exu_md_pkg::DIV: begin
                if (b == '0) begin
                    res = '1;
                end else if (ovf) begin
                    res = a;
                end else begin
                    // signed quotient, truncated toward zero
                    sres = $signed(a) / $signed(b);
                    res  = sres;
                end
            end
            exu_md_pkg::DIVU: res = (b == '0) ? '1 : a / b;
            exu_md_pkg::REM: begin
                if (b == '0) begin
                    res = a;
                end else if (ovf) begin
                    res = '0;
                end else begin
                    // remainder takes the dividend sign
                    sres = $signed(a) % $signed(b);
                    res  = sres;
                end
            end
            default:          res = (b == '0) ? a : a % b;
        endcase
        return res;
    endfunction

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
        tests++;
    endtask

    task automatic finish_test();
        $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic check_idle();
        checks++;
        test_checks++;
        assert (!wb_valid_o && !stall_o) else begin
            $display("FAILED %s wb_valid_o/stall_o: expected 0/0 actual %b/%b",
                     test_name, wb_valid_o, stall_o);
            count_error();
        end
    endtask

    // called at the negedge before the accepting edge
    task automatic record_accept();
        logic [ID_W-1:0] id;
        id = req_data_i.commit_id;
        if (req_data_i.we) begin
            pending[id]  = 1'b1;
            exp_data[id] = model_result(req_data_i.op, req_data_i.rs1, req_data_i.rs2);
            exp_addr[id] = req_data_i.waddr;
            acc_edge[id] = cycle_cnt + 1;
            exp_lat[id]  = req_data_i.op[2] ? DIV_WB_LAT : MUL_LAT;
            lat_chk[id]  = lat_en;
            outstanding++;
        end
        next_id = next_id + ID_W'(1);
    endtask

    task automatic check_writeback();
        logic [ID_W-1:0] id;
        id = wb_o.commit_id;
        checks++;
        test_checks++;
        assert (pending[id]) else begin
            $display("unexpected writeback for commit id %0d in test %s", id, test_name);
            count_error();
        end
        if (pending[id]) begin
            assert (wb_o.wdata == exp_data[id]) else begin
                $display("FAILED %s wdata of id %0d: expected %h actual %h",
                         test_name, id, exp_data[id], wb_o.wdata);
                count_error();
            end
            assert (wb_o.waddr == exp_addr[id]) else begin
                $display("FAILED %s waddr of id %0d: expected %0d actual %0d",
                         test_name, id, exp_addr[id], wb_o.waddr);
                count_error();
            end
            // cycles from accepting edge to the edge that raised wb_valid_o
            if (lat_chk[id]) begin
                assert (cycle_cnt - acc_edge[id] == exp_lat[id]) else begin
                    $display("FAILED %s latency of id %0d: expected %0d actual %0d",
                             test_name, id, exp_lat[id], cycle_cnt - acc_edge[id]);
                    count_error();
                end
            end
            pending[id] = 1'b0;
            outstanding--;
        end
    endtask

    // holds the request until an edge takes it, a flushed one for one cycle only
    task automatic send_request(input exu_md_pkg::md_op_e op, input logic we, input logic flush,
                                input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                input logic [exu_md_pkg::REG_ADDR_W-1:0] waddr);
        logic accepted;
        logic done;
        req_data_i.op        = op;
        req_data_i.rs1       = a;
        req_data_i.rs2       = b;
        req_data_i.waddr     = waddr;
        req_data_i.we        = we;
        req_data_i.commit_id = next_id;
        req_i   = 1'b1;
        flush_i = flush;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            accepted = !flush_i && !stall_o;
            if (accepted) begin
                record_accept();
            end
            @(posedge clk);
            #2;
            done = accepted || flush;
        end
        req_i   = 1'b0;
        flush_i = 1'b0;
    endtask

    // random operands biased toward the corner values
    task automatic issue(input exu_md_pkg::md_op_e op, input logic we, input logic flush);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        r1 = rand_word();
        r2 = rand_word();
        r3 = rand_word();
        r4 = rand_word();
        send_request(op, we, flush, pick_operand(r1, r2), pick_operand(r3, r4),
                     r2[exu_md_pkg::REG_ADDR_W-1:0]);
    endtask

    // ends at a drive point once every expected result has left or the wait runs out
    task automatic drain();
        int waited;
        waited = 0;
        while (outstanding != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        #2;
        checks++;
        test_checks++;
        assert (outstanding == 0) else begin
            $display("%0d results were never written back in test %s", outstanding, test_name);
            count_error();
        end
    endtask

    // edge counter and run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // writeback port sampled between edges
    always @(negedge clk) begin
        if (arst_n_i && wb_valid_o && wb_ready_i) begin
            check_writeback();
        end
    end

    // back-pressure, random only in the mixed test
    initial begin
        wb_ready_i  = 1'b1;
        ready_state = SEED;
        forever begin
            @(posedge clk);
            #2;
            if (random_ready) begin
                ready_state = lcg_next(ready_state);
                wb_ready_i  = (ready_state[31:30] != 2'b00);
            end else begin
                wb_ready_i = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] r;
        arst_n_i     = 1'b1;
        req_i        = 1'b0;
        flush_i      = 1'b0;
        req_data_i   = '0;
        random_ready = 1'b0;
        lat_en       = 1'b0;
        lcg_state    = SEED;
        next_id      = '0;
        outstanding  = 0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        for (int i = 0; i < IDS; i++) begin
            pending[i] = 1'b0;
        end
        #1;
        arst_n_i = 1'b0;

        start_test("reset");
        repeat (7) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        // first edge after release
        @(posedge clk);
        @(negedge clk);
        check_idle();
        finish_test();
        @(posedge clk);
        #2;

        start_test("multiply");
        lat_en = 1'b1;
        repeat (100) begin
            r = rand_word();
            issue(exu_md_pkg::md_op_e'({1'b0, r[1:0]}), 1'b1, 1'b0);
        end
        drain();
        finish_test();

        start_test("divide");
        repeat (60) begin
            r = rand_word();
            issue(exu_md_pkg::md_op_e'({1'b1, r[1:0]}), 1'b1, 1'b0);
        end
        // overflow and zero divisor every time
        send_request(exu_md_pkg::DIV, 1'b1, 1'b0, MOST_NEG, '1, 5'd3);
        send_request(exu_md_pkg::REM, 1'b1, 1'b0, MOST_NEG, '1, 5'd4);
        send_request(exu_md_pkg::DIV, 1'b1, 1'b0, XLEN'(123), '0, 5'd5);
        send_request(exu_md_pkg::REMU, 1'b1, 1'b0, XLEN'(123), '0, 5'd6);
        drain();
        finish_test();

        start_test("mixed");
        lat_en       = 1'b0;
        random_ready = 1'b1;
        repeat (160) begin
            r = rand_word();
            issue(exu_md_pkg::md_op_e'(r[2:0]), r[5:3] != 3'b000, r[9:6] == 4'b0000);
        end
        drain();
        random_ready = 1'b0;
        finish_test();

        // a quarter flushed, a quarter with we low
        start_test("flush_we");
        repeat (40) begin
            r = rand_word();
            issue(exu_md_pkg::md_op_e'(r[2:0]), r[4:3] != 2'b01, r[4:3] == 2'b00);
        end
        drain();
        // long enough for a stray divide to show up
        repeat (DIV_WB_LAT + 2) @(posedge clk);
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/exu_md_pkg.sv
logic/exu_mul.sv
logic/exu_div_ctrl.sv
logic/exu_divider.sv
logic/exu_wb_arb.sv
logic/exu_muldiv_top.sv
tb/exu_muldiv_properties.sv
tb/tb_exu_muldiv.sv

// ==== run_verilator.sh ====
#!/bin/sh
# build and run the multiply/divide cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_exu_muldiv \
    -f vlog.f \
    -o sim_exu_muldiv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_exu_muldiv)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Everything OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
